// ==== compile.f ====
dual_issue_pkg.sv
pair_receiver.sv
exec_lane.sv
reg_file.sv
dual_issue_core.sv
tb_clock_gen.sv
tb_dual_issue.sv

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pair_req,
    input  dual_issue_pkg::inst_word_t pair_inst0,
    input  dual_issue_pkg::inst_word_t pair_inst1,
    input  logic                       pair_has_inst1,
    output logic                       pair_ack,
    output logic                       trace0_we,
    output dual_issue_pkg::reg_addr_t  trace0_dest,
    output dual_issue_pkg::word_t      trace0_data,
    output logic                       trace1_we,
    output dual_issue_pkg::reg_addr_t  trace1_dest,
    output dual_issue_pkg::word_t      trace1_data
);
    import dual_issue_pkg::*;

    logic       issue0_valid;
    logic       issue1_valid;
    inst_word_t issue0_inst;
    inst_word_t issue1_inst;

    reg_addr_t  rs0_addr;
    reg_addr_t  rt0_addr;
    reg_addr_t  rs1_addr;
    reg_addr_t  rt1_addr;
    word_t      rs0_data;
    word_t      rt0_data;
    word_t      rs1_data;
    word_t      rt1_data;

    logic       ex0_we;
    reg_addr_t  ex0_dest;
    word_t      ex0_data;
    logic       ex1_we;
    reg_addr_t  ex1_dest;
    word_t      ex1_data;

    pair_receiver rx0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .pair_req       (pair_req),
        .pair_inst0     (pair_inst0),
        .pair_inst1     (pair_inst1),
        .pair_has_inst1 (pair_has_inst1),
        .pair_ack       (pair_ack),
        .issue0_valid   (issue0_valid),
        .issue0_inst    (issue0_inst),
        .issue1_valid   (issue1_valid),
        .issue1_inst    (issue1_inst)
    );

    // Lane 0 always holds the older instruction
    exec_lane lane0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue0_valid),
        .issue_inst  (issue0_inst),
        .rs_data     (rs0_data),
        .rt_data     (rt0_data),
        .rs_addr     (rs0_addr),
        .rt_addr     (rt0_addr),
        .ex_we       (ex0_we),
        .ex_dest     (ex0_dest),
        .ex_data     (ex0_data),
        .wb_we       (trace0_we),
        .wb_dest     (trace0_dest),
        .wb_data     (trace0_data)
    );

    exec_lane lane1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue1_valid),
        .issue_inst  (issue1_inst),
        .rs_data     (rs1_data),
        .rt_data     (rt1_data),
        .rs_addr     (rs1_addr),
        .rt_addr     (rt1_addr),
        .ex_we       (ex1_we),
        .ex_dest     (ex1_dest),
        .ex_data     (ex1_data),
        .wb_we       (trace1_we),
        .wb_dest     (trace1_dest),
        .wb_data     (trace1_data)
    );

    reg_file rf0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd0_rs      (rs0_addr),
        .rd0_rt      (rt0_addr),
        .rd1_rs      (rs1_addr),
        .rd1_rt      (rt1_addr),
        .ex0_we      (ex0_we),
        .ex0_dest    (ex0_dest),
        .ex0_data    (ex0_data),
        .ex1_we      (ex1_we),
        .ex1_dest    (ex1_dest),
        .ex1_data    (ex1_data),
        .wb0_we      (trace0_we),
        .wb0_dest    (trace0_dest),
        .wb0_data    (trace0_data),
        .wb1_we      (trace1_we),
        .wb1_dest    (trace1_dest),
        .wb1_data    (trace1_data),
        .rd0_rs_data (rs0_data),
        .rd0_rt_data (rt0_data),
        .rd1_rs_data (rs1_data),
        .rd1_rt_data (rt1_data)
    );

endmodule

// ==== dual_issue_pkg.sv ====
package dual_issue_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // One instruction word, seen either as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;
        } i;
    } inst_word_t;

    localparam int NUM_REGS = 32;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

endpackage

// ==== exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue_valid,
    input  dual_issue_pkg::inst_word_t issue_inst,
    input  dual_issue_pkg::word_t      rs_data,
    input  dual_issue_pkg::word_t      rt_data,
    output dual_issue_pkg::reg_addr_t  rs_addr,
    output dual_issue_pkg::reg_addr_t  rt_addr,
    output logic                       ex_we,
    output dual_issue_pkg::reg_addr_t  ex_dest,
    output dual_issue_pkg::word_t      ex_data,
    output logic                       wb_we,
    output dual_issue_pkg::reg_addr_t  wb_dest,
    output dual_issue_pkg::word_t      wb_data
);
    import dual_issue_pkg::*;

    alu_op_t   id_op;
    logic      id_legal;
    logic      id_is_shift;
    logic      id_zext;
    logic      id_use_imm;
    reg_addr_t id_dest;
    word_t     id_imm;
    word_t     id_a;
    word_t     id_b;

    alu_op_t   ex_op;
    word_t     ex_a;
    word_t     ex_b;

    assign rs_addr = issue_inst.r.rs;
    assign rt_addr = issue_inst.r.rt;

    always_comb begin
        id_op       = ALU_ADD;
        id_legal    = 1'b1;
        id_is_shift = 1'b0;
        id_zext     = 1'b0;
        id_use_imm  = 1'b1;
        id_dest     = issue_inst.i.rt;
        case (issue_inst.r.opcode)
            OP_SPECIAL: begin
                id_use_imm = 1'b0;
                id_dest    = issue_inst.r.rd;
                case (issue_inst.r.funct)
                    FN_ADDU: id_op = ALU_ADD;
                    FN_SUBU: id_op = ALU_SUB;
                    FN_AND:  id_op = ALU_AND;
                    FN_OR:   id_op = ALU_OR;
                    FN_XOR:  id_op = ALU_XOR;
                    FN_NOR:  id_op = ALU_NOR;
                    FN_SLT:  id_op = ALU_SLT;
                    FN_SLTU: id_op = ALU_SLTU;
                    FN_SLL: begin
                        id_op       = ALU_SLL;
                        id_is_shift = 1'b1;
                    end
                    FN_SRL: begin
                        id_op       = ALU_SRL;
                        id_is_shift = 1'b1;
                    end
                    default: id_legal = 1'b0;
                endcase
            end
            OP_ADDIU: id_op = ALU_ADD;
            OP_SLTI:  id_op = ALU_SLT;
            OP_ANDI: begin
                id_op   = ALU_AND;
                id_zext = 1'b1;
            end
            OP_ORI: begin
                id_op   = ALU_OR;
                id_zext = 1'b1;
            end
            OP_XORI: begin
                id_op   = ALU_XOR;
                id_zext = 1'b1;
            end
            OP_LUI:  id_op = ALU_LUI;
            default: id_legal = 1'b0;
        endcase
    end

    assign id_imm = id_zext ? {16'h0000, issue_inst.i.imm}
                            : {{16{issue_inst.i.imm[15]}}, issue_inst.i.imm};

    // Shifts move rt by shamt
    assign id_a = id_is_shift ? rt_data : rs_data;
    assign id_b = id_is_shift ? {27'd0, issue_inst.r.shamt} :
                  id_use_imm  ? id_imm : rt_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_we <= 1'b0;
            wb_we <= 1'b0;
        end else begin
            // Undefined ops and r0 targets retire silently
            ex_we <= issue_valid && id_legal && (id_dest != '0);
            wb_we <= ex_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_op   <= id_op;
        ex_a    <= id_a;
        ex_b    <= id_b;
        ex_dest <= id_dest;
        wb_dest <= ex_dest;
        wb_data <= ex_data;
    end

    always_comb begin
        case (ex_op)
            ALU_ADD:  ex_data = ex_a + ex_b;
            ALU_SUB:  ex_data = ex_a - ex_b;
            ALU_AND:  ex_data = ex_a & ex_b;
            ALU_OR:   ex_data = ex_a | ex_b;
            ALU_XOR:  ex_data = ex_a ^ ex_b;
            ALU_NOR:  ex_data = ~(ex_a | ex_b);
            ALU_SLT:  ex_data = {31'd0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU: ex_data = {31'd0, ex_a < ex_b};
            ALU_SLL:  ex_data = ex_a << ex_b[4:0];
            ALU_SRL:  ex_data = ex_a >> ex_b[4:0];
            ALU_LUI:  ex_data = {ex_b[15:0], 16'h0000};
            default:  ex_data = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> wb_dest != '0);

endmodule

// ==== pair_receiver.sv ====
`timescale 1ns/1ps

module pair_receiver (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pair_req,
    input  dual_issue_pkg::inst_word_t pair_inst0,
    input  dual_issue_pkg::inst_word_t pair_inst1,
    input  logic                       pair_has_inst1,
    output logic                       pair_ack,
    output logic                       issue0_valid,
    output dual_issue_pkg::inst_word_t issue0_inst,
    output logic                       issue1_valid,
    output dual_issue_pkg::inst_word_t issue1_inst
);
    import dual_issue_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HOLD = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;
    localparam logic [1:0] S_ACK  = 2'd3;

    logic [1:0] state;
    logic       inst0_is_r;
    logic       inst1_is_r;
    reg_addr_t  inst0_dest;
    logic       depends;

    assign inst0_is_r = pair_inst0.r.opcode == OP_SPECIAL;
    assign inst1_is_r = pair_inst1.r.opcode == OP_SPECIAL;
    assign inst0_dest = inst0_is_r ? pair_inst0.r.rd : pair_inst0.i.rt;

    // rt is a source only for R-type, for I-type it is the destination
    assign depends = (inst0_dest != '0) &&
                     ((pair_inst1.i.rs == inst0_dest) ||
                      (inst1_is_r && pair_inst1.r.rt == inst0_dest));

    assign pair_ack = state == S_ACK;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            issue0_valid <= 1'b0;
            issue1_valid <= 1'b0;
        end else begin
            issue0_valid <= 1'b0;
            issue1_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (pair_req) begin
                        issue0_valid <= 1'b1;
                        if (pair_has_inst1 && !depends) begin
                            issue1_valid <= 1'b1;
                            state        <= S_DONE;
                        end else if (pair_has_inst1) begin
                            state <= S_HOLD;
                        end else begin
                            state <= S_DONE;
                        end
                    end
                end
                // Second one waits a cycle so it can take lane 0's EX result
                S_HOLD: begin
                    issue1_valid <= 1'b1;
                    state        <= S_DONE;
                end
                S_DONE: begin
                    state <= S_ACK;
                end
                S_ACK: begin
                    if (!pair_req) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Source holds the pair stable while req is high
    always_ff @(posedge clk) begin
        issue0_inst <= pair_inst0;
        issue1_inst <= pair_inst1;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        pair_ack && pair_req |=> pair_ack);

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dual_issue_pkg::reg_addr_t rd0_rs,
    input  dual_issue_pkg::reg_addr_t rd0_rt,
    input  dual_issue_pkg::reg_addr_t rd1_rs,
    input  dual_issue_pkg::reg_addr_t rd1_rt,
    input  logic                      ex0_we,
    input  dual_issue_pkg::reg_addr_t ex0_dest,
    input  dual_issue_pkg::word_t     ex0_data,
    input  logic                      ex1_we,
    input  dual_issue_pkg::reg_addr_t ex1_dest,
    input  dual_issue_pkg::word_t     ex1_data,
    input  logic                      wb0_we,
    input  dual_issue_pkg::reg_addr_t wb0_dest,
    input  dual_issue_pkg::word_t     wb0_data,
    input  logic                      wb1_we,
    input  dual_issue_pkg::reg_addr_t wb1_dest,
    input  dual_issue_pkg::word_t     wb1_data,
    output dual_issue_pkg::word_t     rd0_rs_data,
    output dual_issue_pkg::word_t     rd0_rt_data,
    output dual_issue_pkg::word_t     rd1_rs_data,
    output dual_issue_pkg::word_t     rd1_rt_data
);
    import dual_issue_pkg::*;

    localparam int NUM_PORTS = 4;

    word_t     regs  [NUM_REGS];
    reg_addr_t raddr [NUM_PORTS];
    word_t     rdata [NUM_PORTS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0_we) begin
                regs[wb0_dest] <= wb0_data;
            end
            // Lane 1 is younger, so its write lands last
            if (wb1_we) begin
                regs[wb1_dest] <= wb1_data;
            end
        end
    end

    assign raddr[0] = rd0_rs;
    assign raddr[1] = rd0_rt;
    assign raddr[2] = rd1_rs;
    assign raddr[3] = rd1_rt;

    // Youngest producer first
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (ex1_we && ex1_dest == raddr[p]) begin
                rdata[p] = ex1_data;
            end else if (ex0_we && ex0_dest == raddr[p]) begin
                rdata[p] = ex0_data;
            end else if (wb1_we && wb1_dest == raddr[p]) begin
                rdata[p] = wb1_data;
            end else if (wb0_we && wb0_dest == raddr[p]) begin
                rdata[p] = wb0_data;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

    assign rd0_rs_data = rdata[0];
    assign rd0_rt_data = rdata[1];
    assign rd1_rs_data = rdata[2];
    assign rd1_rt_data = rdata[3];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module tb_dual_issue -o tb_dual_issue

# The simulator's exit status is ignored here, the log decides
./obj_dir/tb_dual_issue 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "FAIL: no result in $LOG"
    exit 1
fi
echo "PASS"

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tb_dual_issue.sv ====
`timescale 1ns/1ps

module tb_dual_issue;
    import dual_issue_pkg::*;

    localparam int CLK_PERIOD = 20;
    // Pairs over all tests
    localparam int NUM_PAIRS = 45;
    localparam int WATCHDOG_CYCLES = NUM_PAIRS * 8 + 50;

    logic       clk;
    logic       rst_n;
    logic       pair_req;
    inst_word_t pair_inst0;
    inst_word_t pair_inst1;
    logic       pair_has_inst1;
    logic       pair_ack;
    logic       trace0_we;
    reg_addr_t  trace0_dest;
    word_t      trace0_data;
    logic       trace1_we;
    reg_addr_t  trace1_dest;
    word_t      trace1_data;

    word_t       ref_regs [NUM_REGS];
    logic [36:0] expected_q [$];
    integer      seed;
    int          pairs_sent;
    int          ack_count;
    logic        ack_seen;

    tb_clock_gen clk_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dual_issue_core dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .pair_req       (pair_req),
        .pair_inst0     (pair_inst0),
        .pair_inst1     (pair_inst1),
        .pair_has_inst1 (pair_has_inst1),
        .pair_ack       (pair_ack),
        .trace0_we      (trace0_we),
        .trace0_dest    (trace0_dest),
        .trace0_data    (trace0_data),
        .trace1_we      (trace1_we),
        .trace1_dest    (trace1_dest),
        .trace1_data    (trace1_data)
    );

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    function automatic inst_word_t encode_r(input logic [5:0] funct, input reg_addr_t rd,
                                            input reg_addr_t rs, input reg_addr_t rt,
                                            input logic [4:0] shamt);
        inst_word_t w;
        w = {OP_SPECIAL, rs, rt, rd, shamt, funct};
        return w;
    endfunction

    function automatic inst_word_t encode_i(input logic [5:0] op, input reg_addr_t rt,
                                            input reg_addr_t rs, input logic [15:0] imm);
        inst_word_t w;
        w = {op, rs, rt, imm};
        return w;
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic reg_addr_t random_src();
        return reg_addr_t'(1 + rand_below(8));
    endfunction

    function automatic logic [5:0] random_rr_funct();
        case (rand_below(8))
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_NOR;
            6: return FN_SLT;
            default: return FN_SLTU;
        endcase
    endfunction

    // Reference model, applied in program order when a pair is offered
    task automatic model_exec(input inst_word_t inst);
        word_t     a;
        word_t     b;
        word_t     sext;
        word_t     zext;
        word_t     res;
        reg_addr_t dest;
        logic      ok;
        a    = ref_regs[inst.r.rs];
        b    = ref_regs[inst.r.rt];
        sext = {{16{inst.i.imm[15]}}, inst.i.imm};
        zext = {16'h0000, inst.i.imm};
        res  = '0;
        ok   = 1'b1;
        dest = inst.i.rt;
        if (inst.r.opcode == OP_SPECIAL) begin
            dest = inst.r.rd;
            case (inst.r.funct)
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_NOR:  res = ~(a | b);
                FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                FN_SLL:  res = b << inst.r.shamt;
                FN_SRL:  res = b >> inst.r.shamt;
                default: ok = 1'b0;
            endcase
        end else begin
            case (inst.i.opcode)
                OP_ADDIU: res = a + sext;
                OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OP_ANDI:  res = a & zext;
                OP_ORI:   res = a | zext;
                OP_XORI:  res = a ^ zext;
                OP_LUI:   res = {inst.i.imm, 16'h0000};
                default:  ok = 1'b0;
            endcase
        end
        if (ok && dest != 5'd0) begin
            ref_regs[dest] = res;
            expected_q.push_back({dest, res});
        end
    endtask

    // Full four-phase handshake for one pair
    task automatic send_pair(input inst_word_t i0, input inst_word_t i1, input logic has1);
        model_exec(i0);
        if (has1) begin
            model_exec(i1);
        end
        pair_inst0     <= i0;
        pair_inst1     <= i1;
        pair_has_inst1 <= has1;
        pair_req       <= 1'b1;
        pairs_sent++;
        do begin
            @(posedge clk);
        end while (pair_ack !== 1'b1);
        pair_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (pair_ack !== 1'b0);
    endtask

    task automatic compare_trace(input int lane, input reg_addr_t dest, input word_t data);
        logic [36:0] head;
        if (expected_q.size() == 0) begin
            $display("Lane %0d wrote r%0d at %0t ns but no write was pending", lane, dest, $time);
            $display("Simulation failed");
            $fatal(1, "unexpected trace write");
        end else begin
            head = expected_q.pop_front();
            check_value($sformatf("lane %0d dest", lane), {27'd0, dest}, {27'd0, head[36:32]});
            check_value($sformatf("lane %0d data", lane), data, head[31:0]);
        end
    endtask

    // Lane 0 holds the older instruction
    always @(posedge clk) begin
        if (trace0_we === 1'b1) begin
            compare_trace(0, trace0_dest, trace0_data);
        end
        if (trace1_we === 1'b1) begin
            compare_trace(1, trace1_dest, trace1_data);
        end
    end

    always @(posedge clk) begin
        if (pair_ack && !ack_seen) begin
            ack_count <= ack_count + 1;
        end
        ack_seen <= pair_ack;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the core stopped responding to instruction pairs");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    task automatic test_independent();
        reg_addr_t d;
        for (int k = 0; k < 4; k++) begin
            d = reg_addr_t'(2 * k + 1);
            send_pair(encode_i(OP_LUI, d, 5'd0, 16'($random(seed))),
                      encode_i(OP_ORI, d + 5'd1, 5'd0, 16'($random(seed))), 1'b1);
        end
        for (int k = 0; k < 8; k++) begin
            send_pair(encode_r(random_rr_funct(), reg_addr_t'(9 + k), random_src(),
                               random_src(), 5'd0),
                      encode_r(random_rr_funct(), reg_addr_t'(17 + k), random_src(),
                               random_src(), 5'd0), 1'b1);
        end
    endtask

    task automatic test_intra_pair_dependency();
        for (int k = 0; k < 6; k++) begin
            if (k % 2 == 0) begin
                send_pair(encode_r(random_rr_funct(), 5'd10, random_src(), random_src(), 5'd0),
                          encode_r(random_rr_funct(), 5'd11, 5'd10, random_src(), 5'd0), 1'b1);
            end else begin
                send_pair(encode_i(OP_ADDIU, 5'd12, random_src(), 16'($random(seed))),
                          encode_r(random_rr_funct(), 5'd13, random_src(), 5'd12, 5'd0), 1'b1);
            end
        end
    endtask

    // Each pair reads both lanes of the pair before and lane 0 of the one before that
    task automatic test_back_to_back();
        reg_addr_t p0;
        reg_addr_t p1;
        reg_addr_t q0;
        reg_addr_t d0;
        reg_addr_t d1;
        p0 = 5'd1;
        p1 = 5'd2;
        q0 = 5'd3;
        for (int k = 0; k < 8; k++) begin
            d0 = reg_addr_t'(20 + (2 * k) % 8);
            d1 = reg_addr_t'(21 + (2 * k) % 8);
            send_pair(encode_r(random_rr_funct(), d0, p0, p1, 5'd0),
                      encode_r(random_rr_funct(), d1, p1, q0, 5'd0), 1'b1);
            q0 = p0;
            p0 = d0;
            p1 = d1;
        end
    endtask

    task automatic test_same_destination();
        send_pair(encode_r(FN_ADDU, 5'd14, 5'd1, 5'd2, 5'd0),
                  encode_r(FN_XOR, 5'd14, 5'd3, 5'd4, 5'd0), 1'b1);
        send_pair(encode_r(FN_OR, 5'd15, 5'd14, 5'd0, 5'd0), '0, 1'b0);
        send_pair(encode_i(OP_ORI, 5'd16, 5'd0, 16'h1234),
                  encode_i(OP_ADDIU, 5'd16, 5'd0, 16'hbeef), 1'b1);
        send_pair(encode_r(FN_ADDU, 5'd17, 5'd16, 5'd0, 5'd0), '0, 1'b0);
    endtask

    task automatic test_extension_and_shifts();
        logic [4:0] shifts [4];
        shifts = '{5'd0, 5'd1, 5'd15, 5'd31};
        // r25 negative, r26 positive
        send_pair(encode_i(OP_LUI, 5'd25, 5'd0, 16'hfedc),
                  encode_i(OP_ORI, 5'd26, 5'd0, 16'h1234), 1'b1);
        send_pair(encode_i(OP_ADDIU, 5'd27, 5'd26, 16'hff00),
                  encode_i(OP_SLTI, 5'd28, 5'd26, 16'hfff0), 1'b1);
        send_pair(encode_i(OP_SLTI, 5'd29, 5'd25, 16'h8000),
                  encode_i(OP_ANDI, 5'd30, 5'd25, 16'hfedc), 1'b1);
        send_pair(encode_i(OP_ORI, 5'd31, 5'd25, 16'hffff),
                  encode_i(OP_XORI, 5'd9, 5'd26, 16'h8001), 1'b1);
        send_pair(encode_i(OP_ANDI, 5'd10, 5'd31, 16'hf0f0),
                  encode_i(OP_ADDIU, 5'd11, 5'd25, 16'h8000), 1'b1);
        for (int k = 0; k < 4; k++) begin
            send_pair(encode_r(FN_SLL, 5'd12, 5'd0, 5'd31, shifts[k]),
                      encode_r(FN_SRL, 5'd13, 5'd0, 5'd31, shifts[k]), 1'b1);
        end
        send_pair(encode_r(FN_SLT, 5'd14, 5'd25, 5'd26, 5'd0),
                  encode_r(FN_SLTU, 5'd15, 5'd25, 5'd26, 5'd0), 1'b1);
        send_pair(encode_r(FN_SLT, 5'd16, 5'd26, 5'd25, 5'd0),
                  encode_r(FN_SLTU, 5'd17, 5'd26, 5'd25, 5'd0), 1'b1);
    endtask

    task automatic test_zero_and_undefined();
        send_pair(encode_i(OP_ORI, 5'd0, 5'd1, 16'h5555),
                  encode_r(FN_ADDU, 5'd0, 5'd2, 5'd3, 5'd0), 1'b1);
        send_pair(encode_i(6'h3f, 5'd18, 5'd0, 16'h0001),
                  encode_r(6'h3f, 5'd19, 5'd0, 5'd0, 5'd0), 1'b1);
        // r0 must still read as zero
        send_pair(encode_r(FN_OR, 5'd20, 5'd0, 5'd1, 5'd0),
                  encode_r(FN_ADDU, 5'd21, 5'd0, 5'd0, 5'd0), 1'b1);
        send_pair(encode_r(FN_OR, 5'd22, 5'd18, 5'd0, 5'd0),
                  encode_r(FN_OR, 5'd23, 5'd19, 5'd0, 5'd0), 1'b1);
    endtask

    initial begin
        pair_req       = 1'b0;
        pair_inst0     = '0;
        pair_inst1     = '0;
        pair_has_inst1 = 1'b0;
        seed           = 32'hd8f2;
        pairs_sent     = 0;
        ack_count      = 0;
        ack_seen       = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        @(posedge rst_n);
        @(posedge clk);
        test_independent();
        test_intra_pair_dependency();
        test_back_to_back();
        test_same_destination();
        test_extension_and_shifts();
        test_zero_and_undefined();
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        // Catch any stray write after the last expected one
        repeat (4) @(posedge clk);
        check_value("handshake count", word_t'(ack_count), word_t'(pairs_sent));
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
